// File: cpu_core.f
+incdir+design
design/cpu_pkg.sv
design/inst_decode.sv
design/alu.sv
design/reg_file.sv
design/cpu_fsm.sv
design/perf_counters.sv
design/cpu_core.sv
testbench/tb_clock.sv
testbench/tb_cpu_core.sv

// File: Makefile
SIM      = verilator
TOP      = tb_cpu_core
FILELIST = cpu_core.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run, check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/tb_cpu_core.sv
`default_nettype none

module tb_cpu_core;
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_pkg::*;

	// Opcodes used by the program builders
	localparam logic [6:0] opc_imm  = 7'h13;
	localparam logic [6:0] opc_load = 7'h03;
	localparam logic [6:0] opc_jalr = 7'h67;
	// jal x0, 0 spins on itself
	localparam word_t halt_word = 32'h0000_006f;

	logic clk;
	logic rst_init;
	logic rst_pulse;
	logic rst;
	word_t pc;
	logic inst_req_valid;
	logic inst_req_ready;
	word_t instruction;
	logic inst_valid;
	logic inst_ready;
	word_t address;
	logic mem_read;
	logic mem_write;
	word_t write_data;
	logic mem_req_ready;
	word_t read_data;
	logic read_data_valid;
	logic read_data_ready;
	perf_cnt_t perf_cnt;

	// Memory models, DUT side and reference side
	word_t imem [256];
	word_t dmem [256];
	word_t ref_dmem [256];
	int fill_idx;
	word_t halt_pc;

	// Observed traffic
	word_t fetch_log [$];
	word_t st_addr [$];
	word_t st_data [$];
	logic stop_seen;
	int edges;
	int stalls;

	// Expected results from the reference model
	word_t exp_pcs [$];
	word_t exp_st_addr [$];
	word_t exp_st_data [$];
	int exp_mem_ops;
	int exp_taken;

	// Channel model state
	int ifr_wait;
	int mr_wait;
	int if_wait;
	int rd_wait;
	logic if_pending;
	logic rd_pending;
	word_t if_addr;
	word_t rd_addr;
	logic held_if;
	logic held_mem;
	word_t if_snap;
	logic [65:0] mem_snap;

	integer seed = 63;
	string cur_test;
	int mismatches;
	int failures;
	int budget;
	int total_edges;

	assign rst = rst_init | rst_pulse;

	tb_clock clock_gen (
		.clk(clk),
		.rst(rst_init)
	);

	cpu_core dut_i (
		.clk            (clk),
		.rst            (rst),
		.pc             (pc),
		.inst_req_valid (inst_req_valid),
		.inst_req_ready (inst_req_ready),
		.instruction    (instruction),
		.inst_valid     (inst_valid),
		.inst_ready     (inst_ready),
		.address        (address),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.write_data     (write_data),
		.mem_req_ready  (mem_req_ready),
		.read_data      (read_data),
		.read_data_valid(read_data_valid),
		.read_data_ready(read_data_ready),
		.perf_cnt       (perf_cnt)
	);

	task automatic log_mismatch(input string what, input word_t exp, input word_t act);
		$display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
		mismatches++;
	endtask

	task automatic flag_error(input string msg);
		$display("Error in %s: %s", cur_test, msg);
		failures++;
	endtask

	// Wait of 0 to 3 cycles
	function automatic int draw_wait();
		draw_wait = $random(seed) & 3;
	endfunction

	// Instruction encoders
	function automatic word_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		r_type = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
	endfunction

	function automatic word_t i_type(input int imm, input int rs1, input logic [2:0] f3,
		input int rd, input logic [6:0] opc);
		i_type = {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic word_t s_type(input int imm, input int rs2, input int rs1);
		s_type = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic word_t b_type(input int imm, input int rs2, input int rs1,
		input logic [2:0] f3);
		b_type = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic word_t lui_word(input int imm20, input int rd);
		lui_word = {imm20[19:0], rd[4:0], 7'h37};
	endfunction

	function automatic word_t j_type(input int imm, input int rd);
		j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
	endfunction

	task automatic emit(input word_t w);
		imem[fill_idx] = w;
		fill_idx++;
	endtask

	task automatic emit_halt();
		halt_pc = word_t'(fill_idx * 4);
		emit(halt_word);
	endtask

	// Fresh memories, data pattern mixes every address bit
	task automatic clear_memories();
		word_t a;
		for (int i = 0; i < 256; i++) begin
			a = word_t'(i * 4);
			// No-op fill, immediate carries the address
			imem[i] = i_type(i * 4, 0, 3'd0, 0, opc_imm);
			dmem[i] = (a * 32'h9e37_79b9) ^ 32'h5a5a_0000;
			ref_dmem[i] = dmem[i];
		end
		fill_idx = 0;
	endtask

	// RV32I subset reference, runs the program up to the halt
	task automatic reference_run();
		word_t r [32];
		word_t p;
		word_t ins;
		word_t a;
		word_t b;
		word_t res;
		word_t t;
		word_t imm_i;
		word_t imm_s;
		word_t imm_b;
		word_t imm_j;
		logic [2:0] f3;
		logic br;
		int n;
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		p = '0;
		n = 0;
		exp_pcs.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		exp_mem_ops = 0;
		exp_taken = 0;
		while (n < 2000) begin
			ins = imem[p[9:2]];
			exp_pcs.push_back(p);
			n++;
			if (ins == halt_word)
				break;
			f3 = ins[14:12];
			a = r[ins[19:15]];
			b = r[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			res = '0;
			case (ins[6:0])
				7'h33, 7'h13: begin
					if (ins[6:0] == 7'h13)
						b = imm_i;
					case (f3)
						3'd0: res = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
						3'd2: res = word_t'($signed(a) < $signed(b));
						3'd3: res = word_t'(a < b);
						3'd4: res = a ^ b;
						3'd6: res = a | b;
						default: res = a & b;
					endcase
					r[ins[11:7]] = res;
					p = p + 4;
				end
				7'h37: begin
					r[ins[11:7]] = {ins[31:12], 12'b0};
					p = p + 4;
				end
				7'h03: begin
					t = a + imm_i;
					r[ins[11:7]] = ref_dmem[t[9:2]];
					exp_mem_ops++;
					p = p + 4;
				end
				7'h23: begin
					t = a + imm_s;
					ref_dmem[t[9:2]] = b;
					exp_st_addr.push_back({t[31:2], 2'b00});
					exp_st_data.push_back(b);
					exp_mem_ops++;
					p = p + 4;
				end
				7'h63: begin
					case (f3)
						3'd0: br = (a == b);
						3'd1: br = (a != b);
						3'd4: br = $signed(a) < $signed(b);
						3'd5: br = $signed(a) >= $signed(b);
						3'd6: br = a < b;
						default: br = a >= b;
					endcase
					if (br) begin
						p = p + imm_b;
						exp_taken++;
					end else begin
						p = p + 4;
					end
				end
				7'h6f: begin
					r[ins[11:7]] = p + 4;
					p = p + imm_j;
					exp_taken++;
				end
				7'h67: begin
					// Target first, rd may be rs1
					t = (a + imm_i) & ~32'h1;
					r[ins[11:7]] = p + 4;
					p = t;
					exp_taken++;
				end
				default: p = p + 4;
			endcase
			r[0] = '0;
		end
		if (n >= 2000)
			flag_error("reference model never reached the halt");
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		rst_pulse <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		// Idle outputs while held in reset
		if (inst_req_valid || mem_read || mem_write)
			flag_error("request output high during reset");
		// Response channels drained during reset
		if (!inst_ready || !read_data_ready)
			flag_error("response ready low during reset");
		if (pc != 32'h0)
			log_mismatch("reset pc", 32'h0, pc);
		for (int i = 0; i < 5; i++)
			if (perf_cnt[i] != 32'h0)
				log_mismatch("reset counter", 32'h0, perf_cnt[i]);
		@(posedge clk);
		rst_pulse <= 1'b0;
	endtask

	task automatic run_program();
		reference_run();
		budget += 40 * exp_pcs.size() + 40;
		pulse_reset();
		while (!stop_seen)
			@(negedge clk);
	endtask

	task automatic compare_run();
		if (fetch_log.size() != exp_pcs.size())
			log_mismatch("fetch count", exp_pcs.size(), fetch_log.size());
		for (int i = 0; i < exp_pcs.size() && i < fetch_log.size(); i++)
			if (fetch_log[i] != exp_pcs[i])
				log_mismatch($sformatf("fetch pc %0d", i), exp_pcs[i], fetch_log[i]);
		if (st_addr.size() != exp_st_addr.size())
			log_mismatch("store count", exp_st_addr.size(), st_addr.size());
		for (int i = 0; i < exp_st_addr.size() && i < st_addr.size(); i++) begin
			if (st_addr[i] != exp_st_addr[i])
				log_mismatch($sformatf("store %0d address", i), exp_st_addr[i], st_addr[i]);
			if (st_data[i] != exp_st_data[i])
				log_mismatch($sformatf("store %0d data", i), exp_st_data[i], st_data[i]);
		end
		for (int i = 0; i < 256; i++)
			if (dmem[i] != ref_dmem[i])
				log_mismatch($sformatf("dmem word %0d", i), ref_dmem[i], dmem[i]);
	endtask

	task automatic compare_counters();
		if (perf_cnt[0] != word_t'(edges))
			log_mismatch("cycle counter", edges, perf_cnt[0]);
		if (perf_cnt[1] != word_t'(exp_pcs.size()))
			log_mismatch("fetch counter", exp_pcs.size(), perf_cnt[1]);
		if (perf_cnt[2] != word_t'(exp_mem_ops))
			log_mismatch("memory access counter", exp_mem_ops, perf_cnt[2]);
		if (perf_cnt[3] != word_t'(stalls))
			log_mismatch("memory stall counter", stalls, perf_cnt[3]);
		if (perf_cnt[4] != word_t'(exp_taken))
			log_mismatch("taken counter", exp_taken, perf_cnt[4]);
	endtask

	task automatic test_reset();
		cur_test = "reset";
		clear_memories();
		emit_halt();
		budget += 80;
		pulse_reset();
		// No memory traffic before the first fetch
		while (!stop_seen) begin
			@(negedge clk);
			if (mem_read || mem_write)
				flag_error("memory request before the first fetch");
		end
		if (fetch_log.size() == 0)
			flag_error("no fetch seen");
		else if (fetch_log[0] != 32'h0)
			log_mismatch("first fetch address", 32'h0, fetch_log[0]);
	endtask

	task automatic test_arith();
		cur_test = "arith";
		clear_memories();
		emit(i_type(512, 0, 3'd0, 10, opc_imm));
		emit(lui_word(20'h12345, 1));
		emit(i_type(12'h678, 1, 3'd0, 1, opc_imm));
		emit(i_type(-5, 0, 3'd0, 2, opc_imm));
		emit(r_type(7'h00, 2, 1, 3'd0, 3));
		emit(r_type(7'h20, 2, 1, 3'd0, 4));
		emit(r_type(7'h00, 2, 1, 3'd7, 5));
		emit(r_type(7'h00, 2, 1, 3'd6, 6));
		emit(r_type(7'h00, 2, 1, 3'd4, 7));
		emit(r_type(7'h00, 1, 2, 3'd2, 8));
		emit(r_type(7'h00, 1, 2, 3'd3, 9));
		for (int k = 3; k <= 9; k++)
			emit(s_type((k - 3) * 4, k, 10));
		// Immediate forms
		emit(i_type(12'h0f0, 1, 3'd7, 3, opc_imm));
		emit(i_type(12'h123, 2, 3'd6, 4, opc_imm));
		emit(i_type(-1, 1, 3'd4, 5, opc_imm));
		emit(i_type(-4, 2, 3'd2, 6, opc_imm));
		emit(i_type(5, 2, 3'd3, 7, opc_imm));
		emit(i_type(-1, 1, 3'd0, 8, opc_imm));
		for (int k = 3; k <= 8; k++)
			emit(s_type(28 + (k - 3) * 4, k, 10));
		emit_halt();
		run_program();
		compare_run();
	endtask

	task automatic test_mem();
		cur_test = "mem";
		clear_memories();
		emit(i_type(512, 0, 3'd0, 10, opc_imm));
		emit(i_type(0, 10, 3'd2, 1, opc_load));
		emit(i_type(4, 10, 3'd2, 2, opc_load));
		emit(r_type(7'h00, 2, 1, 3'd0, 3));
		emit(s_type(8, 3, 10));
		emit(i_type(8, 10, 3'd2, 4, opc_load));
		emit(i_type(1, 4, 3'd0, 4, opc_imm));
		emit(s_type(12, 4, 10));
		emit(i_type(12, 10, 3'd2, 5, opc_load));
		emit(i_type(1, 5, 3'd0, 5, opc_imm));
		emit(s_type(16, 5, 10));
		emit(s_type(-4, 1, 10));
		emit_halt();
		run_program();
		compare_run();
	endtask

	task automatic test_control();
		int f3s [12];
		int rs1s [12];
		int rs2s [12];
		int k;
		cur_test = "control";
		// Each condition taken, then not taken
		f3s = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
		rs1s = '{1, 1, 1, 1, 2, 1, 1, 2, 1, 2, 2, 1};
		rs2s = '{3, 2, 2, 3, 1, 2, 2, 1, 2, 1, 1, 2};
		clear_memories();
		emit(i_type(512, 0, 3'd0, 10, opc_imm));
		emit(i_type(5, 0, 3'd0, 1, opc_imm));
		emit(i_type(-3, 0, 3'd0, 2, opc_imm));
		emit(i_type(5, 0, 3'd0, 3, opc_imm));
		emit(i_type(0, 0, 3'd0, 20, opc_imm));
		for (int i = 0; i < 12; i++) begin
			emit(b_type(8, rs2s[i], rs1s[i], 3'(f3s[i])));
			emit(i_type(1, 20, 3'd0, 20, opc_imm));
		end
		emit(j_type(8, 21));
		emit(i_type(1, 20, 3'd0, 20, opc_imm));
		// JALR to an odd target, bit 0 dropped
		k = fill_idx;
		emit(i_type((k + 3) * 4, 0, 3'd0, 23, opc_imm));
		emit(i_type(1, 23, 3'd0, 22, opc_jalr));
		emit(i_type(1, 20, 3'd0, 20, opc_imm));
		// Short backward loop
		emit(i_type(3, 0, 3'd0, 24, opc_imm));
		emit(i_type(-1, 24, 3'd0, 24, opc_imm));
		emit(b_type(-4, 0, 24, 3'd1));
		emit(s_type(0, 20, 10));
		emit(s_type(4, 21, 10));
		emit(s_type(8, 22, 10));
		emit(s_type(12, 24, 10));
		emit_halt();
		run_program();
		compare_run();
	endtask

	task automatic test_counters();
		cur_test = "counters";
		clear_memories();
		emit(i_type(512, 0, 3'd0, 10, opc_imm));
		emit(i_type(4, 0, 3'd0, 5, opc_imm));
		// Increment four words in place
		emit(i_type(0, 10, 3'd2, 1, opc_load));
		emit(i_type(1, 1, 3'd0, 1, opc_imm));
		emit(s_type(0, 1, 10));
		emit(i_type(4, 10, 3'd0, 10, opc_imm));
		emit(i_type(-1, 5, 3'd0, 5, opc_imm));
		emit(b_type(-20, 0, 5, 3'd1));
		emit(j_type(8, 0));
		emit(i_type(1, 0, 3'd0, 6, opc_imm));
		emit_halt();
		run_program();
		compare_run();
		compare_counters();
	endtask

	// Memory models, all channel inputs driven on the rising edge
	always @(posedge clk) begin
		int w;
		if (rst) begin
			inst_req_ready <= 1'b0;
			inst_valid <= 1'b0;
			mem_req_ready <= 1'b0;
			read_data_valid <= 1'b0;
			ifr_wait = -1;
			mr_wait = -1;
			if_pending = 1'b0;
			rd_pending = 1'b0;
			held_if = 1'b0;
			held_mem = 1'b0;
			edges = 0;
			stalls = 0;
			stop_seen = 1'b0;
			fetch_log.delete();
			st_addr.delete();
			st_data.delete();
		end else begin
			edges++;
			// Unaccepted requests must hold still
			if (held_if && (!inst_req_valid || pc != if_snap))
				flag_error("fetch request changed before it was accepted");
			if (held_mem && ({mem_read, mem_write, address, write_data} != mem_snap))
				flag_error("memory request changed before it was accepted");
			held_if = 1'b0;
			held_mem = 1'b0;
			// Responses in flight
			if (inst_valid && inst_ready) begin
				inst_valid <= 1'b0;
			end else if (if_pending) begin
				if (if_wait == 0) begin
					inst_valid <= 1'b1;
					instruction <= imem[if_addr[9:2]];
					if_pending = 1'b0;
				end else begin
					if_wait--;
				end
			end
			if (read_data_valid && read_data_ready) begin
				read_data_valid <= 1'b0;
			end else if (rd_pending) begin
				if (rd_wait == 0) begin
					read_data_valid <= 1'b1;
					read_data <= dmem[rd_addr[9:2]];
					rd_pending = 1'b0;
				end else begin
					rd_wait--;
				end
			end
			// Fetch request channel
			if (inst_req_valid && inst_req_ready) begin
				inst_req_ready <= 1'b0;
				ifr_wait = -1;
				fetch_log.push_back(pc);
				if (pc == halt_pc)
					stop_seen = 1'b1;
				w = draw_wait();
				if (w == 0) begin
					inst_valid <= 1'b1;
					instruction <= imem[pc[9:2]];
				end else begin
					if_wait = w - 1;
					if_addr = pc;
					if_pending = 1'b1;
				end
			end else if (inst_req_valid) begin
				held_if = 1'b1;
				if_snap = pc;
				if (ifr_wait < 0)
					ifr_wait = draw_wait();
				if (ifr_wait == 0)
					inst_req_ready <= 1'b1;
				else
					ifr_wait--;
			end
			// Memory request channel
			if ((mem_read || mem_write) && mem_req_ready) begin
				mem_req_ready <= 1'b0;
				mr_wait = -1;
				if (mem_write) begin
					dmem[address[9:2]] = write_data;
					st_addr.push_back(address);
					st_data.push_back(write_data);
				end else begin
					w = draw_wait();
					// Read data wait cycles stall the core
					stalls += w;
					if (w == 0) begin
						read_data_valid <= 1'b1;
						read_data <= dmem[address[9:2]];
					end else begin
						rd_wait = w - 1;
						rd_addr = address;
						rd_pending = 1'b1;
					end
				end
			end else if (mem_read || mem_write) begin
				held_mem = 1'b1;
				mem_snap = {mem_read, mem_write, address, write_data};
				stalls++;
				if (mr_wait < 0)
					mr_wait = draw_wait();
				if (mr_wait == 0)
					mem_req_ready <= 1'b1;
				else
					mr_wait--;
			end
		end
	end

	// Watchdog, budget grows with each program
	always @(posedge clk) begin
		total_edges++;
		if (total_edges > budget) begin
			$display("Timeout: run exceeded %0d cycles in test %s", budget, cur_test);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		rst_pulse = 1'b0;
		inst_req_ready = 1'b0;
		instruction = '0;
		inst_valid = 1'b0;
		mem_req_ready = 1'b0;
		read_data = '0;
		read_data_valid = 1'b0;
		halt_pc = '0;
		mismatches = 0;
		failures = 0;
		budget = 200;
		total_edges = 0;
		cur_test = "startup";
		wait (!rst_init);
		test_reset();
		test_arith();
		test_mem();
		test_control();
		test_counters();
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Power-on reset, two rising edges
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: design/cpu_core.sv
`default_nettype none

`include "cpu_params.svh"

module cpu_core (
	input  logic               clk,
	input  logic               rst,
	// Fetch request
	output cpu_pkg::word_t     pc,
	output logic               inst_req_valid,
	input  logic               inst_req_ready,
	// Fetch response
	input  cpu_pkg::word_t     instruction,
	input  logic               inst_valid,
	output logic               inst_ready,
	// Memory request, word access only
	output cpu_pkg::word_t     address,
	output logic               mem_read,
	output logic               mem_write,
	output cpu_pkg::word_t     write_data,
	input  logic               mem_req_ready,
	// Read response
	input  cpu_pkg::word_t     read_data,
	input  logic               read_data_valid,
	output logic               read_data_ready,
	output cpu_pkg::perf_cnt_t perf_cnt
);
	import cpu_pkg::*;

	word_t        fetched_pc;
	word_t        instr_q;
	word_t        read_data_q;
	decoded_t     dec;
	word_t        rdata1;
	word_t        rdata2;
	word_t        alu_b;
	word_t        alu_result;
	logic         alu_zero;
	logic         br_cond;
	logic         taken;
	word_t        target;
	word_t        link;
	word_t        wb_data;
	fsm_state_t   state;
	perf_events_t events;

	// PC of the instruction being fetched, kept for targets and links
	always_ff @(posedge clk) begin
		if (state == st_if)
			fetched_pc <= pc;
	end

	always_ff @(posedge clk) begin
		if (inst_ready && inst_valid)
			instr_q <= instruction;
	end

	always_ff @(posedge clk) begin
		if (read_data_ready && read_data_valid)
			read_data_q <= read_data;
	end

	// Step on fetch response, redirect at end of execute
	always_ff @(posedge clk) begin
		if (rst)
			pc <= `CPU_RESET_PC;
		else if (state == st_iw && inst_valid)
			pc <= pc + `CPU_XLEN'd4;
		else if (state == st_ex && taken)
			pc <= target;
	end

	inst_decode u_decode (
		.instruction(instr_q),
		.dec        (dec)
	);

	reg_file u_regs (
		.clk   (clk),
		.raddr1(dec.rs1),
		.raddr2(dec.rs2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.wen   (state == st_wb),
		.waddr (dec.rd),
		.wdata (wb_data)
	);

	// Second operand is rs2 for register ops and branches
	assign alu_b = dec.use_imm ? dec.imm : rdata2;

	alu u_alu (
		.a     (rdata1),
		.b     (alu_b),
		.op    (dec.alu_op),
		.result(alu_result),
		.zero  (alu_zero)
	);

	// Branch condition from funct3
	always_comb begin
		case (dec.funct3)
			3'b000:         br_cond = alu_zero;
			3'b001:         br_cond = !alu_zero;
			// blt and bltu, set bit from slt/sltu
			3'b100, 3'b110: br_cond = alu_result[0];
			3'b101, 3'b111: br_cond = !alu_result[0];
			default:        br_cond = 1'b0;
		endcase
	end

	assign taken = (dec.op_class == op_branch && br_cond) ||
		dec.op_class == op_jal || dec.op_class == op_jalr;

	// JALR target is rs1 + imm with bit 0 cleared
	assign target = (dec.op_class == op_jalr) ? {alu_result[`CPU_XLEN-1:1], 1'b0} :
		fetched_pc + dec.imm;
	assign link = fetched_pc + `CPU_XLEN'd4;

	// Write-back select
	always_comb begin
		case (dec.op_class)
			op_lui:           wb_data = dec.imm;
			op_load:          wb_data = read_data_q;
			op_jal, op_jalr:  wb_data = link;
			default:          wb_data = alu_result;
		endcase
	end

	// Word aligned address from rs1 + imm
	assign address    = {alu_result[`CPU_XLEN-1:2], 2'b00};
	assign write_data = rdata2;

	cpu_fsm u_fsm (
		.clk            (clk),
		.rst            (rst),
		.op_class       (dec.op_class),
		.taken          (taken),
		.inst_req_ready (inst_req_ready),
		.inst_valid     (inst_valid),
		.mem_req_ready  (mem_req_ready),
		.read_data_valid(read_data_valid),
		.inst_req_valid (inst_req_valid),
		.inst_ready     (inst_ready),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.read_data_ready(read_data_ready),
		.state          (state),
		.events         (events)
	);

	perf_counters u_perf (
		.clk   (clk),
		.rst   (rst),
		.events(events),
		.cnt   (perf_cnt)
	);

endmodule

`default_nettype wire

// File: design/perf_counters.sv
`default_nettype none

`include "cpu_params.svh"

module perf_counters (
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_pkg::perf_events_t events,
	output cpu_pkg::perf_cnt_t    cnt
);
	import cpu_pkg::*;

	// Strobes as a vector, bit i drives counter i
	logic [`CPU_PERF_NUM-1:0] strobe;
	word_t                    cnt_q [`CPU_PERF_NUM];

	assign strobe = events;

	for (genvar i = 0; i < `CPU_PERF_NUM; i++) begin : g_cnt
		// Free running, wraps at the top
		always_ff @(posedge clk) begin
			if (rst)
				cnt_q[i] <= '0;
			else if (strobe[i])
				cnt_q[i] <= cnt_q[i] + 1'b1;
		end

		assign cnt[i] = cnt_q[i];
	end

endmodule

`default_nettype wire

// File: design/cpu_fsm.sv
`default_nettype none

module cpu_fsm (
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_pkg::op_class_t    op_class,
	input  logic                  taken,
	input  logic                  inst_req_ready,
	input  logic                  inst_valid,
	input  logic                  mem_req_ready,
	input  logic                  read_data_valid,
	output logic                  inst_req_valid,
	output logic                  inst_ready,
	output logic                  mem_read,
	output logic                  mem_write,
	output logic                  read_data_ready,
	output cpu_pkg::fsm_state_t   state,
	output cpu_pkg::perf_events_t events
);
	import cpu_pkg::*;

	fsm_state_t next_state;

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_rst;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			st_rst: next_state = st_if;
			// Wait for the fetch request to be accepted
			st_if:  if (inst_req_ready) next_state = st_iw;
			st_iw:  if (inst_valid) next_state = st_id;
			st_id:  next_state = st_ex;
			st_ex: begin
				case (op_class)
					op_alu, op_lui, op_jal, op_jalr: next_state = st_wb;
					op_load:  next_state = st_ld;
					op_store: next_state = st_st;
					// Branches and no-ops finish here
					default:  next_state = st_if;
				endcase
			end
			st_ld:  if (mem_req_ready) next_state = st_rdw;
			// Store done once accepted
			st_st:  if (mem_req_ready) next_state = st_if;
			st_rdw: if (read_data_valid) next_state = st_wb;
			st_wb:  next_state = st_if;
			default: next_state = st_rst;
		endcase
	end

	// Channel controls straight from the state
	assign inst_req_valid  = (state == st_if);
	// Ready in reset too, so stray responses are drained
	assign inst_ready      = (state == st_rst) || (state == st_iw);
	assign read_data_ready = (state == st_rst) || (state == st_rdw);
	assign mem_read        = (state == st_ld);
	assign mem_write       = (state == st_st);

	// Counter strobes
	// Every cycle out of reset
	assign events.cycle      = !rst;
	assign events.fetch      = inst_req_valid && inst_req_ready;
	assign events.mem_access = (mem_read || mem_write) && mem_req_ready;
	assign events.mem_stall  = ((mem_read || mem_write) && !mem_req_ready) ||
		(state == st_rdw && !read_data_valid);
	assign events.taken      = (state == st_ex) && taken;

	// Never a read and a write at once
	assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
	else $error("cpu_fsm: mem_read and mem_write both high");

	// Read request held until accepted
	assert property (@(posedge clk) disable iff (rst)
		(mem_read && !mem_req_ready) |=> mem_read)
	else $error("cpu_fsm: mem_read dropped before mem_req_ready");

endmodule

`default_nettype wire

// File: design/reg_file.sv
`default_nettype none

`include "cpu_params.svh"

module reg_file (
	input  logic               clk,
	input  cpu_pkg::reg_addr_t raddr1,
	input  cpu_pkg::reg_addr_t raddr2,
	output cpu_pkg::word_t     rdata1,
	output cpu_pkg::word_t     rdata2,
	input  logic               wen,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::word_t     wdata
);
	import cpu_pkg::*;

	word_t regs [`CPU_REG_NUM];

	// x0 is never written
	always_ff @(posedge clk) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// Combinational reads, x0 forced to zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	// A register written on one edge reads back on both ports the next cycle
	assert property (@(posedge clk) (wen && waddr != '0) |=>
		((raddr1 != $past(waddr)) || (rdata1 == $past(wdata))) &&
		((raddr2 != $past(waddr)) || (rdata2 == $past(wdata))))
	else $error("reg_file: written register did not read back");

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu (
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	input  cpu_pkg::alu_op_t op,
	output cpu_pkg::word_t   result,
	output logic             zero
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			// Set-less-than gives 0 or 1
			alu_slt:  result = word_t'($signed(a) < $signed(b));
			alu_sltu: result = word_t'(a < b);
			default:  result = '0;
		endcase
	end

	// Equality test for beq/bne
	assign zero = (result == '0);

	// Decoder must never hand over an encoding outside the enum
	// Unknown op before the first fetch is skipped
	always_comb begin
		if (!$isunknown(op))
			assert (op inside {alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu})
			else $error("alu: undefined op %0d", op);
	end

endmodule

`default_nettype wire

// File: design/inst_decode.sv
`default_nettype none

module inst_decode (
	input  cpu_pkg::word_t    instruction,
	output cpu_pkg::decoded_t dec
);
	import cpu_pkg::*;

	// Major opcodes of the subset
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       shift_free;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;

	// funct3 to ALU op, shared by register and immediate forms
	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sub);
		case (f3)
			3'b000:  arith_op = sub ? alu_sub : alu_add;
			3'b010:  arith_op = alu_slt;
			3'b011:  arith_op = alu_sltu;
			3'b100:  arith_op = alu_xor;
			3'b110:  arith_op = alu_or;
			3'b111:  arith_op = alu_and;
			default: arith_op = alu_add;
		endcase
	endfunction

	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];
	// Shift encodings are outside the subset
	assign shift_free = (funct3 != 3'b001) && (funct3 != 3'b101);

	// Sign-extended immediates, all formats
	assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
	assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
	assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
		instruction[30:25], instruction[11:8], 1'b0};
	assign imm_u = {instruction[31:12], 12'b0};
	assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
		instruction[20], instruction[30:21], 1'b0};

	always_comb begin
		dec.rd       = instruction[11:7];
		dec.rs1      = instruction[19:15];
		dec.rs2      = instruction[24:20];
		dec.funct3   = funct3;
		// Defaults give a no-op
		dec.op_class = op_nop;
		dec.alu_op   = alu_add;
		dec.imm      = '0;
		dec.use_imm  = 1'b0;
		case (opcode)
			opc_op: begin
				// Only funct7 0, or 0100000 for sub
				if (shift_free && (funct7 == 7'b0 ||
						(funct7 == 7'b0100000 && funct3 == 3'b000))) begin
					dec.op_class = op_alu;
					dec.alu_op   = arith_op(funct3, funct7[5]);
				end
			end
			opc_op_imm: begin
				if (shift_free) begin
					dec.op_class = op_alu;
					dec.alu_op   = arith_op(funct3, 1'b0);
					dec.imm      = imm_i;
					dec.use_imm  = 1'b1;
				end
			end
			opc_load: begin
				// Word loads only
				if (funct3 == 3'b010) begin
					dec.op_class = op_load;
					dec.imm      = imm_i;
					dec.use_imm  = 1'b1;
				end
			end
			opc_store: begin
				if (funct3 == 3'b010) begin
					dec.op_class = op_store;
					dec.imm      = imm_s;
					dec.use_imm  = 1'b1;
				end
			end
			opc_branch: begin
				// 010 and 011 are not branches
				if (funct3[2:1] != 2'b01) begin
					dec.op_class = op_branch;
					dec.imm      = imm_b;
					// beq/bne compare by subtraction
					if (!funct3[2])
						dec.alu_op = alu_sub;
					else
						dec.alu_op = funct3[1] ? alu_sltu : alu_slt;
				end
			end
			opc_lui: begin
				dec.op_class = op_lui;
				dec.imm      = imm_u;
			end
			opc_jal: begin
				dec.op_class = op_jal;
				dec.imm      = imm_j;
			end
			opc_jalr: begin
				if (funct3 == 3'b000) begin
					dec.op_class = op_jalr;
					dec.imm      = imm_i;
					dec.use_imm  = 1'b1;
				end
			end
			default: begin
				dec.op_class = op_nop;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

	// Data, address or instruction word
	typedef logic [`CPU_XLEN-1:0] word_t;

	// Register index
	typedef logic [$clog2(`CPU_REG_NUM)-1:0] reg_addr_t;

	// Control FSM states, one-hot
	typedef enum logic [8:0] {
		st_rst = 9'b000000001,
		st_if  = 9'b000000010,
		st_iw  = 9'b000000100,
		st_id  = 9'b000001000,
		st_ex  = 9'b000010000,
		st_ld  = 9'b000100000,
		st_st  = 9'b001000000,
		st_rdw = 9'b010000000,
		st_wb  = 9'b100000000
	} fsm_state_t;

	// Instruction class, picks the path after execute
	typedef enum logic [2:0] {
		op_alu,
		op_lui,
		op_load,
		op_store,
		op_branch,
		op_jal,
		op_jalr,
		op_nop
	} op_class_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu
	} alu_op_t;

	// Decoder output
	typedef struct packed {
		op_class_t op_class;
		alu_op_t   alu_op;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t     imm;
		logic      use_imm;
		// Branch condition
		logic [2:0] funct3;
	} decoded_t;

	// One-cycle event strobes, cycle in the low bit
	typedef struct packed {
		logic taken;
		logic mem_stall;
		logic mem_access;
		logic fetch;
		logic cycle;
	} perf_events_t;

	typedef word_t [`CPU_PERF_NUM-1:0] perf_cnt_t;

endpackage

`default_nettype wire

// File: design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data, address and instruction width
`define CPU_XLEN 32

// Architectural registers, x0 included
`define CPU_REG_NUM 32

// Address of the first fetch after reset
`define CPU_RESET_PC 32'h0000_0000

// Performance counters
// 0 cycles, 1 fetches, 2 memory accesses, 3 memory stalls, 4 taken
`define CPU_PERF_NUM 5

`endif
